/* project.f */
design/flash_pkg.sv
design/spi_link.sv
design/command_sequencer.sv
design/transaction_fsm.sv
design/write_address_tracker.sv
design/flash_spi_top.sv
verification/flash_spi_props.sv
verification/flash_spi_tb.sv

/* verification/flash_spi_golden.txt */
// op section at @000 holds the op count, then per op mode address nbytes key nframes
// followed by the write bytes or expected read bytes; frame section at @080 holds
// the frame count, then per frame bit length, shift word and the byte returned on spi_miso
@000
5
// read three bytes from 0x001234
0 001234 3 00 4 a5 3c 7e
// write two bytes inside one page
1 002010 2 00 7 11 22
// write four bytes across the 0x000200 page boundary
1 0001fe 4 00 c 81 82 83 84
// block erase released with the key
2 030000 0 d8 6
// erase released with a wrong key, no frame
2 040000 0 5a 0
@080
1d
// read
20 03001234 00
08 00000000 a5
08 00000000 3c
08 00000000 7e
// write in one page
08 06000000 00
20 02002010 00
08 11000000 00
08 22000000 00
10 05000000 01
10 05000000 00
08 04000000 00
// write across the page boundary
08 06000000 00
20 020001fe 00
08 81000000 00
08 82000000 00
10 05000000 01
10 05000000 00
08 06000000 00
20 02000200 00
08 83000000 00
08 84000000 00
10 05000000 00
08 04000000 00
// block erase
08 06000000 00
20 d8030000 00
10 05000000 03
10 05000000 01
10 05000000 00
08 04000000 00

/* verification/flash_spi_tb.sv */
// testbench for the serial NOR flash controller
// plays the host and the external SPI shift engine
// host operations and expected frames come from the golden data file
// engine busy time is drawn from an xorshift generator
// ends with one line of error counts and the verdict
`timescale 1ns/1ns

module flash_spi_tb;

    localparam int CS_DELAY     = 2;
    localparam int HALF_PERIOD  = 50;   // 100 ns clock
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 5;    // ns after the rising edge
    localparam int BUSY_MAX     = 4;
    localparam int IDLE_CYCLES  = 4;    // quiet check after reset and after the last op
    localparam int OP_SLACK     = 32;   // accept and release of one op
    localparam int FRAME_BASE   = 'h80; // frame section of the data file
    localparam logic [1:0] OP_READ  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_ERASE = 2'd2;

    logic        CLK;
    logic        RESET_n;
    logic        enable_n;
    logic [1:0]  mode;
    logic [23:0] address;
    logic        req_n;
    logic [7:0]  wdata;
    logic        ack_n;
    logic [7:0]  rdata;
    logic        spi_busy;
    logic [7:0]  spi_miso;
    logic        spi_req;
    logic [31:0] spi_word;
    logic [5:0]  spi_len;
    logic        spi_cs_n;

    logic [31:0] gold [0:255];
    logic        gold_loaded = 1'b0;
    int          frame_idx = 0;         // frames taken by the engine model
    int          frame_goal = 0;        // frames expected up to the current op
    int          value_errors = 0;
    int          protocol_errors = 0;
    logic [31:0] rng = 32'h1b2e;

    flash_spi_top #(.CS_DELAY(CS_DELAY)) uut (
        .CLK(CLK),
        .RESET_n(RESET_n),
        .enable_n(enable_n),
        .mode(mode),
        .address(address),
        .req_n(req_n),
        .wdata(wdata),
        .ack_n(ack_n),
        .rdata(rdata),
        .spi_busy(spi_busy),
        .spi_miso(spi_miso),
        .spi_req(spi_req),
        .spi_word(spi_word),
        .spi_len(spi_len),
        .spi_cs_n(spi_cs_n)
    );

    initial
    begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error: %s = %h, expected %h at %0t", name, got, exp, $time);
        value_errors++;
    endtask

    task automatic next_cycle;
        @(posedge CLK);
        #DRIVE_DELAY;   // outputs settled and inputs change here
    endtask

    task automatic wait_ack(input logic level);
        while (ack_n !== level)
            next_cycle();
    endtask

    // ack_n, chip select and the request strobe stay inactive with no op running
    task automatic check_idle_outputs;
        for (int i = 0; i < IDLE_CYCLES; i++)
        begin
            next_cycle();
            if (ack_n !== 1'b1)
                report_mismatch("ack_n", ack_n, 1);
            if (spi_cs_n !== 1'b1)
                report_mismatch("spi_cs_n", spi_cs_n, 1);
            if (spi_req !== 1'b0)
                report_mismatch("spi_req", spi_req, 0);
        end
    endtask

    task automatic print_counts;
        $display("errors: value %0d, protocol %0d, assertion %0d",
                 value_errors, protocol_errors, uut.u_props.assert_failures);
    endtask

    // runs one host operation from the op section and moves ptr to the next record
    task automatic run_op(inout int ptr);
        logic [1:0] op_mode;
        logic [7:0] key;
        logic [7:0] data;
        int         nbytes;
        int         nframes;
        bit         cs_went_low;
        op_mode     = gold[ptr][1:0];
        nbytes      = gold[ptr + 2];
        key         = gold[ptr + 3][7:0];
        nframes     = gold[ptr + 4];
        cs_went_low = 1'b0;
        frame_goal += nframes;
        mode        = op_mode;
        address     = gold[ptr + 1][23:0];
        enable_n    = 1'b0;
        wait_ack(1'b0);                     // accepted
        if (op_mode == OP_ERASE)
        begin
            wdata    = key;
            enable_n = 1'b1;                // key decides on release
        end
        else
        begin
            wait_ack(1'b1);                 // ready for the first byte
            for (int i = 0; i < nbytes; i++)
            begin
                data = gold[ptr + 5 + i][7:0];
                if (op_mode == OP_WRITE)
                    wdata = data;           // held until ack_n rises
                req_n = 1'b0;
                wait_ack(1'b0);
                req_n = 1'b1;
                wait_ack(1'b1);
                if (op_mode == OP_READ && rdata !== data)
                    report_mismatch("rdata", rdata, data);
            end
            enable_n = 1'b1;
        end
        // wait until all frames ran and both chip select and ack_n are high
        while (frame_idx < frame_goal || spi_cs_n !== 1'b1 || ack_n !== 1'b1)
        begin
            if (nframes == 0 && spi_cs_n !== 1'b1 && !cs_went_low)
            begin
                $display("spi_cs_n went low on an erase released without the key");
                protocol_errors++;
                cs_went_low = 1'b1;
            end
            next_cycle();
        end
        if (frame_idx != frame_goal)
        begin
            $display("operation ended after frame %0d, expected end at frame %0d",
                     frame_idx, frame_goal);
            protocol_errors++;
        end
        ptr += 5 + nbytes;
    endtask

    // SPI engine model replaying the frame records in order
    initial
    begin : engine
        int          base;
        int          busy_cycles;
        logic [31:0] exp_len;
        logic [31:0] exp_word;
        logic [31:0] mask;
        logic [7:0]  reply;
        spi_busy = 1'b0;
        spi_miso = 8'h00;
        wait (gold_loaded);
        forever
        begin
            next_cycle();
            if (spi_req === 1'b1 && spi_busy === 1'b0)
            begin
                reply = 8'h00;
                if (frame_idx >= gold[FRAME_BASE])
                begin
                    $display("frame %0d requested beyond the expected frame list", frame_idx);
                    protocol_errors++;
                end
                else
                begin
                    base     = FRAME_BASE + 1 + 3 * frame_idx;
                    exp_len  = gold[base];
                    exp_word = gold[base + 1];
                    reply    = gold[base + 2][7:0];
                    mask     = ~(32'hffff_ffff >> exp_len);    // shifted bits only
                    if (spi_len !== exp_len[5:0])
                        report_mismatch("spi_len", spi_len, exp_len);
                    if ((spi_word & mask) !== (exp_word & mask))
                        report_mismatch("spi_word", spi_word, exp_word);
                end
                frame_idx++;
                rng = xorshift32(rng);
                busy_cycles = rng % BUSY_MAX + 1;
                spi_busy = 1'b1;
                repeat (busy_cycles) @(posedge CLK);
                #DRIVE_DELAY;
                spi_miso = reply;           // valid from the busy fall
                spi_busy = 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        int limit;
        wait (gold_loaded);
        limit = RESET_CYCLES + 2 * IDLE_CYCLES + gold[0] * OP_SLACK
              + gold[FRAME_BASE] * (BUSY_MAX + 4 * CS_DELAY + 8);
        repeat (limit) @(posedge CLK);
        $display("timeout, run still busy after %0d clock cycles", limit);
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin : host
        int ptr;
        int n_ops;
        RESET_n  = 1'b0;
        enable_n = 1'b1;
        mode     = 2'd0;
        address  = 24'h0;
        req_n    = 1'b1;
        wdata    = 8'h00;
        $readmemh("verification/flash_spi_golden.txt", gold);
        gold_loaded = 1'b1;
        n_ops = gold[0];
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        RESET_n = 1'b1;
        check_idle_outputs();       // nothing moves before enable_n falls
        ptr = 1;
        for (int op = 0; op < n_ops; op++)
            run_op(ptr);
        check_idle_outputs();       // no stray frame after the last op
        print_counts();
        if (value_errors + protocol_errors + uut.u_props.assert_failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verification/flash_spi_props.sv */
// concurrent checks on the SPI engine strobes of the flash controller
// bound into flash_spi_top, looks at chip-select framing and the request strobe
`timescale 1ns/1ns

module flash_spi_props (
    input logic CLK,
    input logic RESET_n,
    input logic spi_req,
    input logic spi_busy,
    input logic spi_cs_n
);

    int assert_failures = 0;    // failures so far

    // a frame is only requested inside a selected window
    req_inside_cs: assert property (@(posedge CLK) disable iff (!RESET_n)
        $rose(spi_req) |-> !spi_cs_n)
    else
    begin
        assert_failures++;
        $error("spi_req rose while spi_cs_n was high");
    end

    // no select edge while the engine shifts
    cs_stable_busy: assert property (@(posedge CLK) disable iff (!RESET_n)
        spi_busy |=> $stable(spi_cs_n))
    else
    begin
        assert_failures++;
        $error("spi_cs_n changed while spi_busy was high");
    end

endmodule

bind flash_spi_top flash_spi_props u_props (
    .CLK(CLK),
    .RESET_n(RESET_n),
    .spi_req(spi_req),
    .spi_busy(spi_busy),
    .spi_cs_n(spi_cs_n)
);

/* design/flash_spi_top.sv */
// serial NOR flash controller, top level
// host side is a four-phase enable/req/ack port for read, write and erase
// SPI side drives an external shift engine through req/busy strobes
// CS_DELAY sets the settle clocks around every chip-select edge
`timescale 1ns/1ns

module flash_spi_top
    import flash_pkg::*;
#(
    parameter int CS_DELAY = 10
)(
    input  logic        CLK,
    input  logic        RESET_n,
    // host port
    input  logic        enable_n,
    input  logic [1:0]  mode,       // read / write / erase encoding
    input  flash_addr_t address,
    input  logic        req_n,
    input  flash_byte_t wdata,
    output logic        ack_n,
    output flash_byte_t rdata,
    // shift engine
    input  logic        spi_busy,
    input  flash_byte_t spi_miso,
    output logic        spi_req,
    output spi_word_t   spi_word,
    output spi_len_t    spi_len,
    output logic        spi_cs_n
);

    logic step, host_step;
    logic seq_start, seq_idle;
    seq_op_t seq_op;

    // request group, link side and host machine side
    logic      xfer_start, cs_assert, cs_release, hold;
    spi_word_t xfer_word;
    spi_len_t  xfer_len;
    logic      h_xfer_start, h_cs_assert, h_cs_release, h_hold;
    spi_word_t h_xfer_word;
    spi_len_t  h_xfer_len;

    // write address tracking
    logic        addr_load, addr_advance, pp_take;
    logic        pp_needed, page_end;
    flash_addr_t pp_addr;

    spi_link #(.CS_DELAY(CS_DELAY)) u_link (
        .CLK, .RESET_n, .spi_busy,
        .xfer_start, .xfer_word, .xfer_len, .cs_assert, .cs_release, .hold,
        .spi_req, .spi_word, .spi_len, .spi_cs_n, .step
    );

    command_sequencer u_seq (
        .CLK, .RESET_n, .step, .seq_start, .seq_op,
        .erase_addr(address),   // host keeps address through the erase
        .pp_addr, .spi_miso,
        .host_xfer_start(h_xfer_start), .host_xfer_word(h_xfer_word),
        .host_xfer_len(h_xfer_len), .host_cs_assert(h_cs_assert),
        .host_cs_release(h_cs_release), .host_hold(h_hold),
        .host_step, .seq_idle,
        .xfer_start, .xfer_word, .xfer_len, .cs_assert, .cs_release, .hold
    );

    transaction_fsm u_fsm (
        .CLK, .RESET_n, .host_step, .seq_idle, .enable_n,
        .mode(flash_mode_t'(mode)),
        .address, .req_n, .wdata, .spi_miso, .pp_needed, .page_end,
        .ack_n, .rdata, .seq_start, .seq_op,
        .host_xfer_start(h_xfer_start), .host_xfer_word(h_xfer_word),
        .host_xfer_len(h_xfer_len), .host_cs_assert(h_cs_assert),
        .host_cs_release(h_cs_release), .host_hold(h_hold),
        .addr_load, .addr_advance, .pp_take
    );

    write_address_tracker u_addr (
        .CLK, .RESET_n, .addr_load, .address, .addr_advance, .pp_take,
        .pp_addr, .pp_needed, .page_end
    );

endmodule

/* design/write_address_tracker.sv */
// write address bookkeeping beside the host machine
// counts the byte address, captures the page-program start address and
// flags when a new write-enable + page-program header is needed
`timescale 1ns/1ns

module write_address_tracker
    import flash_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        addr_load,      // write accepted
    input  flash_addr_t address,
    input  logic        addr_advance,   // one byte sent
    input  logic        pp_take,        // header issued at current address
    output flash_addr_t pp_addr,
    output logic        pp_needed,
    output logic        page_end        // advance lands on a page boundary
);

    flash_addr_t addr;

    assign page_end = &addr[PAGE_BITS-1:0];

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
            pp_needed <= 1'b0;
        else if (addr_load || (addr_advance && page_end))
            pp_needed <= 1'b1;  // fresh write or next page
        else if (pp_take)
            pp_needed <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (addr_load)
            addr <= address;
        else if (addr_advance)
            addr <= addr + 1'b1;
        if (pp_take)
            pp_addr <= addr;
    end

endmodule

/* design/transaction_fsm.sv */
// host protocol machine of the flash controller
// accepts read, write and erase on enable_n and paces each byte on req_n/ack_n
// single frames go straight to the link, multi-frame work is handed to the
// sequencer with seq_start/seq_op; everything advances on host_step only
`timescale 1ns/1ns

module transaction_fsm
    import flash_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        host_step,
    input  logic        seq_idle,
    input  logic        enable_n,
    input  flash_mode_t mode,
    input  flash_addr_t address,
    input  logic        req_n,
    input  flash_byte_t wdata,
    input  flash_byte_t spi_miso,
    input  logic        pp_needed,
    input  logic        page_end,
    output logic        ack_n,
    output flash_byte_t rdata,
    output logic        seq_start,
    output seq_op_t     seq_op,
    output logic        host_xfer_start,
    output spi_word_t   host_xfer_word,
    output spi_len_t    host_xfer_len,
    output logic        host_cs_assert,
    output logic        host_cs_release,
    output logic        host_hold,
    output logic        addr_load,
    output logic        addr_advance,
    output logic        pp_take
);

    typedef enum logic [3:0] {
        T_IDLE,
        T_RD_CMD, T_RD_WAIT, T_RD_BYTE, T_RD_END,
        T_ER_WAIT, T_ER_ERASE, T_ER_POLL, T_ER_WRDI,
        T_WR_WAIT, T_WR_CHECK, T_WR_PP, T_WR_SEND, T_WR_WRDI
    } t_state_t;

    t_state_t state;
    logic     go;

    assign go = host_step && seq_idle;  // link free and no sub-operation running
    assign seq_start = go && (seq_op != SEQ_NONE);

    always_comb
    begin
        seq_op          = SEQ_NONE;
        host_xfer_start = 1'b0;
        host_xfer_word  = '0;
        host_xfer_len   = 6'd8;
        host_cs_assert  = 1'b0;
        host_cs_release = 1'b0;
        host_hold       = 1'b0;
        addr_load       = 1'b0;
        addr_advance    = 1'b0;
        pp_take         = 1'b0;
        if (go)
        begin
            case (state)
                T_IDLE:
                    if (!enable_n && mode == MODE_READ)
                        host_cs_assert = 1'b1;
                    else if (!enable_n && mode == MODE_WRITE)
                        addr_load = 1'b1;
                T_RD_CMD:
                begin
                    host_xfer_start = 1'b1;
                    host_xfer_word  = {CMD_READ, address};
                    host_xfer_len   = 6'd32;
                end
                T_RD_WAIT:
                    if (enable_n)
                        host_hold = 1'b1;           // trailing hold before deselect
                    else if (!req_n)
                        host_xfer_start = 1'b1;     // dummy byte out, data in
                T_RD_END: host_cs_release = 1'b1;
                T_ER_WAIT:
                    if (enable_n && wdata == CMD_BLOCK_ERASE)
                        seq_op = SEQ_WRITE_ENABLE;
                T_ER_ERASE: seq_op = SEQ_BLOCK_ERASE;
                T_ER_POLL:  seq_op = SEQ_WAIT_WIP;
                T_ER_WRDI, T_WR_WRDI: seq_op = SEQ_WRITE_DISABLE;
                T_WR_WAIT:
                    if (enable_n)
                        seq_op = SEQ_WAIT_WIP;      // finish the last page
                T_WR_CHECK:
                    if (req_n && pp_needed)
                        seq_op = SEQ_WRITE_ENABLE;
                T_WR_PP:
                begin
                    seq_op  = SEQ_PAGE_PROGRAM;
                    pp_take = 1'b1;
                end
                T_WR_SEND:
                begin
                    host_xfer_start = 1'b1;
                    host_xfer_word  = {wdata, 24'h0};
                    addr_advance    = 1'b1;
                    if (page_end)
                        seq_op = SEQ_WAIT_WIP;      // page full, let it program
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state <= T_IDLE;
            ack_n <= 1'b1;
        end
        else if (go)
        begin
            case (state)
                T_IDLE:
                    if (enable_n)
                        ack_n <= 1'b1;
                    else
                    begin
                        ack_n <= 1'b0;  // accepted
                        case (mode)
                            MODE_READ:  state <= T_RD_CMD;
                            MODE_WRITE: state <= T_WR_WAIT;
                            default:    state <= T_ER_WAIT;
                        endcase
                    end
                T_RD_CMD: state <= T_RD_WAIT;
                T_RD_WAIT:
                    if (enable_n)
                        state <= T_RD_END;
                    else if (!req_n)
                    begin
                        ack_n <= 1'b0;
                        state <= T_RD_BYTE;
                    end
                    else
                        ack_n <= 1'b1;
                T_RD_BYTE:
                    if (req_n)
                    begin
                        rdata <= spi_miso;  // frame is done on any step
                        ack_n <= 1'b1;
                        state <= T_RD_WAIT;
                    end
                T_RD_END: state <= T_IDLE;
                T_ER_WAIT:
                    if (enable_n)
                        state <= (wdata == CMD_BLOCK_ERASE) ? T_ER_ERASE : T_IDLE;
                T_ER_ERASE: state <= T_ER_POLL;
                T_ER_POLL:  state <= T_ER_WRDI;
                T_WR_WAIT:
                    if (enable_n)
                        state <= T_WR_WRDI;
                    else if (!req_n)
                    begin
                        ack_n <= 1'b0;
                        state <= T_WR_CHECK;
                    end
                    else
                        ack_n <= 1'b1;  // byte written, wdata may change
                T_WR_CHECK:
                    if (req_n)
                        state <= pp_needed ? T_WR_PP : T_WR_SEND;
                T_WR_PP:   state <= T_WR_SEND;
                T_WR_SEND: state <= T_WR_WAIT;
                default:   state <= T_IDLE;    // write-disable issued
            endcase
        end
    end

endmodule

/* design/command_sequencer.sv */
// multi-frame flash sub-operations between the host machine and the link
// idle: passes step on as host_step and forwards the host request group
// busy: uses each step itself to run write enable/disable, block erase,
// the page-program header, or the status poll loop on the WIP bit
`timescale 1ns/1ns

module command_sequencer
    import flash_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        step,
    input  logic        seq_start,
    input  seq_op_t     seq_op,
    input  flash_addr_t erase_addr,
    input  flash_addr_t pp_addr,
    input  flash_byte_t spi_miso,
    // host request group
    input  logic        host_xfer_start,
    input  spi_word_t   host_xfer_word,
    input  spi_len_t    host_xfer_len,
    input  logic        host_cs_assert,
    input  logic        host_cs_release,
    input  logic        host_hold,
    output logic        host_step,
    output logic        seq_idle,
    // link request group
    output logic        xfer_start,
    output spi_word_t   xfer_word,
    output spi_len_t    xfer_len,
    output logic        cs_assert,
    output logic        cs_release,
    output logic        hold
);

    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_CS_LOW,      // select + setup delay
        SQ_SEND,        // command frame
        SQ_TAIL,        // trailing hold
        SQ_RELEASE      // deselect, poll decision
    } sq_state_t;

    sq_state_t state;
    seq_op_t   op;          // running sub-operation
    logic      polled;      // a status frame has been read
    spi_word_t frame_word;
    spi_len_t  frame_len;

    // command frame per sub-operation
    always_comb
    begin
        frame_len = 6'd8;
        case (op)
            SEQ_WRITE_DISABLE: frame_word = {CMD_WRITE_DISABLE, 24'h0};
            SEQ_WAIT_WIP:
            begin
                frame_word = {CMD_READ_STATUS, 24'h0};
                frame_len  = 6'd16; // opcode + status byte
            end
            SEQ_BLOCK_ERASE:
            begin
                frame_word = {CMD_BLOCK_ERASE, erase_addr};
                frame_len  = 6'd32;
            end
            SEQ_PAGE_PROGRAM:
            begin
                frame_word = {CMD_PAGE_PROGRAM, pp_addr};
                frame_len  = 6'd32;
            end
            default: frame_word = {CMD_WRITE_ENABLE, 24'h0};
        endcase
    end

    assign seq_idle  = (state == SQ_IDLE);
    assign host_step = step && seq_idle;

    always_comb
    begin
        if (seq_idle)
        begin
            xfer_start = host_xfer_start;   // host owns the link
            xfer_word  = host_xfer_word;
            xfer_len   = host_xfer_len;
            cs_assert  = host_cs_assert;
            cs_release = host_cs_release;
            hold       = host_hold;
        end
        else
        begin
            xfer_start = (state == SQ_SEND);
            xfer_word  = frame_word;
            xfer_len   = frame_len;
            cs_assert  = (state == SQ_CS_LOW);
            cs_release = (state == SQ_RELEASE);
            hold       = (state == SQ_TAIL);
        end
    end

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state  <= SQ_IDLE;
            op     <= SEQ_NONE;
            polled <= 1'b0;
        end
        else if (step)
        begin
            case (state)
                SQ_IDLE:
                    if (seq_start && seq_op != SEQ_NONE)
                    begin
                        op     <= seq_op;
                        polled <= 1'b0;
                        // poll first closes a frame that may still be open
                        state  <= (seq_op == SEQ_WAIT_WIP) ? SQ_TAIL : SQ_CS_LOW;
                    end
                SQ_CS_LOW: state <= SQ_SEND;
                SQ_SEND:
                begin
                    polled <= (op == SEQ_WAIT_WIP);
                    // page-program header keeps cs low for the data bytes
                    state  <= (op == SEQ_PAGE_PROGRAM) ? SQ_IDLE : SQ_TAIL;
                end
                SQ_TAIL: state <= SQ_RELEASE;
                SQ_RELEASE:
                    if (op == SEQ_WAIT_WIP && !(polled && !spi_miso[0]))
                        state <= SQ_CS_LOW;     // WIP set or not read yet
                    else
                        state <= SQ_IDLE;
                default: state <= SQ_IDLE;
            endcase
        end
    end

endmodule

/* design/spi_link.sv */
// engine side registers of the flash controller
// owns spi_req/word/len and chip select, plus the settle-delay counter
// step goes high when no delay runs, no request is pending and the engine
// is idle; request pulses are only taken on a step, one group per step
`timescale 1ns/1ns

module spi_link
    import flash_pkg::*;
#(
    parameter int CS_DELAY = 10
)(
    input  logic      CLK,
    input  logic      RESET_n,
    input  logic      spi_busy,
    // request group
    input  logic      xfer_start,   // start a frame with word and length
    input  spi_word_t xfer_word,
    input  spi_len_t  xfer_len,
    input  logic      cs_assert,    // cs low, then settle
    input  logic      cs_release,   // cs high, then settle
    input  logic      hold,         // settle only
    // engine strobes
    output logic      spi_req,
    output spi_word_t spi_word,
    output spi_len_t  spi_len,
    output logic      spi_cs_n,
    output logic      step
);

    localparam int CNT_W = (CS_DELAY > 0) ? $clog2(CS_DELAY + 1) : 1;
    localparam logic [CNT_W-1:0] DELAY_LOAD = CNT_W'(CS_DELAY);

    logic [CNT_W-1:0] delay_cnt;

    assign step = (delay_cnt == '0) && !spi_req && !spi_busy;

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            spi_req   <= 1'b0;
            spi_cs_n  <= 1'b1;
            delay_cnt <= '0;
        end
        else if (delay_cnt != '0)
        begin
            delay_cnt <= delay_cnt - 1'b1;  // settling
        end
        else if (spi_req)
        begin
            if (spi_busy)
                spi_req <= 1'b0;    // engine took the frame
        end
        else if (step)
        begin
            if (xfer_start)
                spi_req <= 1'b1;
            if (cs_assert)
            begin
                spi_cs_n  <= 1'b0;
                delay_cnt <= DELAY_LOAD;    // setup before first clock
            end
            else if (cs_release)
            begin
                spi_cs_n  <= 1'b1;
                delay_cnt <= DELAY_LOAD;    // deselect time
            end
            else if (hold)
                delay_cnt <= DELAY_LOAD;    // trailing hold, cs unchanged
        end
    end

    // frame payload, stable while spi_req is high
    always_ff @(posedge CLK)
    begin
        if (step && xfer_start)
        begin
            spi_word <= xfer_word;
            spi_len  <= xfer_len;
        end
    end

endmodule

/* design/flash_pkg.sv */
// shared types and constants for the serial NOR flash controller
// widths, flash opcodes, page geometry and the sequencer op codes
// imported by every RTL module of the controller
package flash_pkg;

    typedef logic [23:0] flash_addr_t;  // flash byte address
    typedef logic [7:0]  flash_byte_t;  // data, status or opcode byte
    typedef logic [31:0] spi_word_t;    // left aligned shift word
    typedef logic [5:0]  spi_len_t;     // bits to shift

    // host operation
    typedef enum logic [1:0] {
        MODE_READ,
        MODE_WRITE,
        MODE_ERASE
    } flash_mode_t;

    // multi frame sub-operations run by the sequencer
    typedef enum logic [2:0] {
        SEQ_NONE,
        SEQ_WRITE_ENABLE,
        SEQ_WRITE_DISABLE,
        SEQ_WAIT_WIP,       // status poll until write done
        SEQ_BLOCK_ERASE,    // 64 KB block
        SEQ_PAGE_PROGRAM    // header only, cs stays low
    } seq_op_t;

    // flash opcodes
    localparam flash_byte_t CMD_READ          = 8'h03;
    localparam flash_byte_t CMD_WRITE_ENABLE  = 8'h06;
    localparam flash_byte_t CMD_WRITE_DISABLE = 8'h04;
    localparam flash_byte_t CMD_READ_STATUS   = 8'h05;
    localparam flash_byte_t CMD_PAGE_PROGRAM  = 8'h02;
    localparam flash_byte_t CMD_BLOCK_ERASE   = 8'hD8; // also the erase key on wdata

    localparam int PAGE_BITS = 8; // 256 byte program page

endpackage
